// ==== logic/fft_gain_pkg.sv ====
package fft_gain_pkg;

    // default width of one sample half (I or Q)
    localparam int PRECISION_DEF = 16;

    // gain fraction is unsigned with 16 fractional bits
    // a fraction value f stands for f / 65536
    localparam int FRAC_BW = 16;

    // product of a signed half and the zero-extended fraction
    // one extra bit gives the unsigned fraction its sign room
    localparam int PROD_BW = PRECISION_DEF + FRAC_BW + 1;

    // signed sample half
    typedef logic signed [PRECISION_DEF-1:0] iq_half_t;

    // i sits in the upper half, q in the lower half
    typedef struct packed {
        iq_half_t i;
        iq_half_t q;
    } iq_pair_t;

    // one stream beat
    // raw is the word as it travels on the stream
    // iq gives the two halves for the arithmetic
    typedef union packed {
        logic [2*PRECISION_DEF-1:0] raw;
        iq_pair_t                   iq;
    } iq_word_u;

endpackage

// ==== logic/fft_gain_ctrl.sv ====
module fft_gain_ctrl
    import fft_gain_pkg::*;
#(
    parameter int GAIN_SCALER_BW = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clk_en,
    // channel bandwidth code, selects the gain
    input  logic [3:0]                ch_bw,
    input  logic                      in_valid,
    input  logic                      out_ready,
    output logic                      in_ready,
    // load enables for the two datapath stages
    output logic                      s1_load,
    output logic                      s2_load,
    output logic                      out_valid,
    // fraction for stage 1, taken from the table as the beat is accepted
    output logic [FRAC_BW-1:0]        fraction,
    // shift amount travelling with the beat held in stage 1
    output logic [GAIN_SCALER_BW-1:0] scaler
);

    // table lookup of the current code
    logic [GAIN_SCALER_BW-1:0] gain_scaler;
    logic [FRAC_BW-1:0]        gain_fraction;

    // stage valid flags
    logic s1_valid;
    logic s2_valid;

    // pipeline may move when the output stage is empty or drained
    logic advance;

    // fixed gain per channel bandwidth
    // scaler is a left shift (power of two), fraction scales below 1.0
    always_comb begin
        case (ch_bw)
            4'd0: begin
                // about 3 dB
                gain_scaler   = GAIN_SCALER_BW'(1);
                gain_fraction = FRAC_BW'(16'hB573);
            end
            4'd1: begin
                // about 6 dB
                gain_scaler   = GAIN_SCALER_BW'(2);
                gain_fraction = FRAC_BW'(16'h809C);
            end
            4'd2: begin
                // just under 6 dB
                gain_scaler   = GAIN_SCALER_BW'(1);
                gain_fraction = FRAC_BW'(16'hFFFF);
            end
            4'd3: begin
                gain_scaler   = GAIN_SCALER_BW'(1);
                gain_fraction = FRAC_BW'(16'hB573);
            end
            4'd4: begin
                // close to unity
                gain_scaler   = GAIN_SCALER_BW'(0);
                gain_fraction = FRAC_BW'(16'hFFFF);
            end
            default: begin
                // unused codes fall back to the 3 dB setting
                gain_scaler   = GAIN_SCALER_BW'(1);
                gain_fraction = FRAC_BW'(16'hB573);
            end
        endcase
    end

    // stage 1 samples the fraction only on s1_load
    assign fraction = gain_fraction;

    // stall logic
    // both stages hold together when the output is full and not taken
    assign advance  = !s2_valid || out_ready;
    assign in_ready = advance;
    assign s2_load  = advance && clk_en;
    assign s1_load  = advance && clk_en;

    assign out_valid = s2_valid;

    // stage valids shift as a pair
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (s2_load) begin
            // in_ready is high here, so in_valid means the beat is taken
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    // keep the shift chosen at acceptance with the beat
    // a ch_bw change later on only hits newer beats
    always_ff @(posedge clk) begin
        if (s1_load) begin
            scaler <= gain_scaler;
        end
    end

endmodule

// ==== logic/iq_frac_mult.sv ====
module iq_frac_mult
    import fft_gain_pkg::*;
#(
    parameter int PRECISION = PRECISION_DEF,
    parameter int USR_ID_BW = 2
) (
    input  logic                      clk,
    input  logic                      s1_load,
    // unsigned fraction, 16 fractional bits
    input  logic [FRAC_BW-1:0]        fraction,
    input  iq_word_u                  in_data,
    input  logic [USR_ID_BW-1:0]      in_user,
    input  logic                      in_last,
    // full precision products, no rounding yet
    output logic signed [PROD_BW-1:0] prod_i,
    output logic signed [PROD_BW-1:0] prod_q,
    output logic [USR_ID_BW-1:0]      s1_user,
    output logic                      s1_last
);

    // fraction with a zero sign bit so the multiply stays signed
    logic signed [FRAC_BW:0] frac_s;

    // sample halves as signed values of the working precision
    logic signed [PRECISION-1:0] half_i;
    logic signed [PRECISION-1:0] half_q;

    // products ahead of the register
    logic signed [PROD_BW-1:0] mult_i;
    logic signed [PROD_BW-1:0] mult_q;

    assign frac_s = $signed({1'b0, fraction});

    // split the stream word into its I and Q halves
    assign half_i = in_data.iq.i;
    assign half_q = in_data.iq.q;

    // both operands signed, result sized to hold the full product
    assign mult_i = PROD_BW'(half_i * frac_s);
    assign mult_q = PROD_BW'(half_q * frac_s);

    // payload register, validity lives in the control block
    always_ff @(posedge clk) begin
        if (s1_load) begin
            prod_i  <= mult_i;
            prod_q  <= mult_q;
            s1_user <= in_user;
            s1_last <= in_last;
        end
    end

endmodule

// ==== logic/iq_shift_sat.sv ====
module iq_shift_sat
    import fft_gain_pkg::*;
#(
    parameter int PRECISION      = PRECISION_DEF,
    parameter int USR_ID_BW      = 2,
    parameter int GAIN_SCALER_BW = 4
) (
    input  logic                      clk,
    input  logic                      s2_load,
    // power of two part of the gain, as left shift
    input  logic [GAIN_SCALER_BW-1:0] scaler,
    input  logic signed [PROD_BW-1:0] prod_i,
    input  logic signed [PROD_BW-1:0] prod_q,
    input  logic [USR_ID_BW-1:0]      s1_user,
    input  logic                      s1_last,
    output iq_word_u                  out_data,
    output logic [USR_ID_BW-1:0]      out_user,
    output logic                      out_last
);

    // enough bits to hold a right shift of up to FRAC_BW
    localparam int SHIFT_W = $clog2(FRAC_BW + 1);

    // signed limits of the output precision, at product width
    localparam logic signed [PROD_BW-1:0] SAT_MAX = PROD_BW'((2 ** (PRECISION - 1)) - 1);
    localparam logic signed [PROD_BW-1:0] SAT_MIN = PROD_BW'(-(2 ** (PRECISION - 1)));

    // net right shift once the fraction point and the scaler are merged
    logic [SHIFT_W-1:0] shamt;

    logic signed [PROD_BW-1:0] shifted_i;
    logic signed [PROD_BW-1:0] shifted_q;

    // repacked word ahead of the output register
    iq_word_u next_word;

    // clamp a shifted product into the signed output range
    function automatic iq_half_t sat_half(input logic signed [PROD_BW-1:0] v);
        iq_half_t res;
        if (v > SAT_MAX) begin
            res = iq_half_t'(SAT_MAX);
        end else if (v < SAT_MIN) begin
            res = iq_half_t'(SAT_MIN);
        end else begin
            res = iq_half_t'(v);
        end
        return res;
    endfunction

    // scaler never exceeds FRAC_BW, so this stays a right shift
    assign shamt = SHIFT_W'(FRAC_BW - int'(scaler));

    // arithmetic shift, rounds toward minus infinity
    assign shifted_i = prod_i >>> shamt;
    assign shifted_q = prod_q >>> shamt;

    // i back to the upper half, q to the lower
    always_comb begin
        next_word      = '0;
        next_word.iq.i = sat_half(shifted_i);
        next_word.iq.q = sat_half(shifted_q);
    end

    // output register, side flags follow their beat
    always_ff @(posedge clk) begin
        if (s2_load) begin
            out_data <= next_word;
            out_user <= s1_user;
            out_last <= s1_last;
        end
    end

endmodule

// ==== logic/fft_gain_top.sv ====
module fft_gain_top
    import fft_gain_pkg::*;
#(
    parameter int PRECISION      = PRECISION_DEF,
    parameter int USR_ID_BW      = 2,
    parameter int GAIN_SCALER_BW = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // low stalls the whole stage
    input  logic                 clk_en,
    // channel bandwidth code
    input  logic [3:0]           ch_bw,
    // input stream
    input  logic                 in_valid,
    input  iq_word_u             in_data,
    input  logic [USR_ID_BW-1:0] in_user,
    input  logic                 in_last,
    output logic                 in_ready,
    // output stream
    output logic                 out_valid,
    output iq_word_u             out_data,
    output logic [USR_ID_BW-1:0] out_user,
    output logic                 out_last,
    input  logic                 out_ready
);

    // stage enables from control
    logic s1_load;
    logic s2_load;

    // gain split into fraction and shift
    logic [FRAC_BW-1:0]        fraction;
    logic [GAIN_SCALER_BW-1:0] scaler;

    // stage 1 results
    logic signed [PROD_BW-1:0] prod_i;
    logic signed [PROD_BW-1:0] prod_q;
    logic [USR_ID_BW-1:0]      s1_user;
    logic                      s1_last;

    // gain table, valids and stall
    fft_gain_ctrl #(
        .GAIN_SCALER_BW (GAIN_SCALER_BW)
    ) u_fft_gain_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .ch_bw     (ch_bw),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .s1_load   (s1_load),
        .s2_load   (s2_load),
        .out_valid (out_valid),
        .fraction  (fraction),
        .scaler    (scaler)
    );

    // multiply by the fraction
    iq_frac_mult #(
        .PRECISION (PRECISION),
        .USR_ID_BW (USR_ID_BW)
    ) u_iq_frac_mult (
        .clk      (clk),
        .s1_load  (s1_load),
        .fraction (fraction),
        .in_data  (in_data),
        .in_user  (in_user),
        .in_last  (in_last),
        .prod_i   (prod_i),
        .prod_q   (prod_q),
        .s1_user  (s1_user),
        .s1_last  (s1_last)
    );

    // shift by the scaler and saturate
    iq_shift_sat #(
        .PRECISION      (PRECISION),
        .USR_ID_BW      (USR_ID_BW),
        .GAIN_SCALER_BW (GAIN_SCALER_BW)
    ) u_iq_shift_sat (
        .clk      (clk),
        .s2_load  (s2_load),
        .scaler   (scaler),
        .prod_i   (prod_i),
        .prod_q   (prod_q),
        .s1_user  (s1_user),
        .s1_last  (s1_last),
        .out_data (out_data),
        .out_user (out_user),
        .out_last (out_last)
    );

endmodule

// ==== tb/fft_gain_sva.sv ====
module fft_gain_sva (
    input logic clk,
    input logic rst_n,
    input logic clk_en,
    input logic in_valid,
    input logic out_ready,
    input logic s1_load,
    input logic out_valid
);

    // a reset edge empties stage 2
    a_reset_empty: assert property (
        @(posedge clk) !rst_n |=> !out_valid
    ) else $error("out_valid high after a reset edge");

    // a beat not taken stays on the output
    a_valid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !(out_ready && clk_en) |=> out_valid
    ) else $error("out_valid dropped while the beat was stalled");

    // a beat taken on one load reaches the output on the next load
    a_beat_reaches_out: assert property (
        @(posedge clk) disable iff (!rst_n)
        s1_load && $past(s1_load && in_valid && rst_n) |=> out_valid
    ) else $error("accepted beat did not reach out_valid after two loads");

endmodule

// attach to every control block
bind fft_gain_ctrl fft_gain_sva u_fft_gain_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .clk_en    (clk_en),
    .in_valid  (in_valid),
    .out_ready (out_ready),
    .s1_load   (s1_load),
    .out_valid (out_valid)
);

// ==== tb/fft_gain_tb.sv ====
module fft_gain_tb
    import fft_gain_pkg::*;
;

    localparam int USR_ID_BW      = 2;
    localparam int GAIN_SCALER_BW = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int DRIVE_DLY      = 1;
    localparam logic [31:0] SEED  = 32'hfe86;

    // 64 sweep beats, 8 saturation beats and 60 in each of the three stream tests
    localparam int NUM_BEATS      = 252;
    localparam int TIMEOUT_CYCLES = 20 * NUM_BEATS + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 clk_en;
    logic [3:0]           ch_bw;
    logic                 in_valid;
    iq_word_u             in_data;
    logic [USR_ID_BW-1:0] in_user;
    logic                 in_last;
    logic                 in_ready;
    logic                 out_valid;
    iq_word_u             out_data;
    logic [USR_ID_BW-1:0] out_user;
    logic                 out_last;
    logic                 out_ready;

    // expected beats with one entry per accepted input
    iq_word_u             want_data_q[$];
    logic [USR_ID_BW-1:0] want_user_q[$];
    logic                 want_last_q[$];
    string                want_name_q[$];

    string       cur_test;
    int          checked_count;
    int          cycle_count;
    logic        ready_rand;
    logic        en_rand;
    logic [31:0] seed_dummy;

    fft_gain_top #(
        .PRECISION      (PRECISION_DEF),
        .USR_ID_BW      (USR_ID_BW),
        .GAIN_SCALER_BW (GAIN_SCALER_BW)
    ) u_fft_gain_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .clk_en    (clk_en),
        .ch_bw     (ch_bw),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_user   (in_user),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_user  (out_user),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // print the reason, then stop the run
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_iq(input string name, input iq_word_u want, input iq_word_u got);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: data expected %h actual %h",
                                name, want.raw, got.raw));
        end
    endtask

    task automatic check_flags(input string name,
                               input logic [USR_ID_BW-1:0] want_user, input logic want_last,
                               input logic [USR_ID_BW-1:0] got_user, input logic got_last);
        if (got_user !== want_user || got_last !== want_last) begin
            abort_run($sformatf("FAILED %s: user/last expected %h/%b actual %h/%b",
                                name, want_user, want_last, got_user, got_last));
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: expected %b actual %b", name, want, got));
        end
    endtask

    // clamp to the signed sample range
    function automatic iq_half_t clamp_half(input longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (PRECISION_DEF - 1)) - 1;
        lo = -(longint'(1) <<< (PRECISION_DEF - 1));
        if (v > hi) begin
            return iq_half_t'(hi);
        end else if (v < lo) begin
            return iq_half_t'(lo);
        end
        return iq_half_t'(v);
    endfunction

    // gain model with table lookup, product, floor shift by FRAC_BW - scaler and clamp
    function automatic iq_word_u ref_gain(input iq_word_u sample, input logic [3:0] code);
        int       sc;
        longint   frac;
        longint   p_i;
        longint   p_q;
        iq_word_u res;
        // power of two part of the gain
        case (code)
            4'd1:    sc = 2;
            4'd4:    sc = 0;
            default: sc = 1;
        endcase
        // codes 0, 3 and above 4 share the B573 fraction
        case (code)
            4'd1:       frac = 'h809C;
            4'd2, 4'd4: frac = 'hFFFF;
            default:    frac = 'hB573;
        endcase
        p_i = longint'(sample.iq.i) * frac;
        p_q = longint'(sample.iq.q) * frac;
        // arithmetic shift of a signed value is floor division
        p_i = p_i >>> (FRAC_BW - sc);
        p_q = p_q >>> (FRAC_BW - sc);
        res.iq.i = clamp_half(p_i);
        res.iq.q = clamp_half(p_q);
        return res;
    endfunction

    task automatic next_drive_point;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // hold the beat until the DUT takes it
    task automatic send_beat(input iq_word_u d, input logic [3:0] code,
                             input logic [USR_ID_BW-1:0] user, input logic last);
        logic taken;
        in_valid = 1'b1;
        in_data  = d;
        ch_bw    = code;
        in_user  = user;
        in_last  = last;
        do begin
            @(negedge clk);
            taken = in_ready && clk_en;
            next_drive_point();
        end while (!taken);
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) next_drive_point();
    endtask

    // wait until every expected beat came out and stage 2 is empty
    task automatic drain;
        do begin
            @(negedge clk);
        end while (want_data_q.size() != 0 || out_valid);
        next_drive_point();
        ready_rand = 1'b0;
        en_rand    = 1'b0;
    endtask

    // out_ready and clk_en are steady or random per cycle
    always @(posedge clk) begin
        #DRIVE_DLY;
        out_ready = ready_rand ? (($urandom % 10) < 7) : 1'b1;
        clk_en    = en_rand ? (($urandom % 4) != 0) : 1'b1;
    end

    // inputs are stable at the falling edge so push what the next rising edge takes
    always @(negedge clk) begin
        if (rst_n && in_valid && in_ready && clk_en) begin
            want_data_q.push_back(ref_gain(in_data, ch_bw));
            want_user_q.push_back(in_user);
            want_last_q.push_back(in_last);
            want_name_q.push_back(cur_test);
        end
    end

    // scoreboard compare at each output transfer
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready && clk_en) begin
            if (want_data_q.size() == 0) begin
                abort_run("an output beat arrived while no beat was expected");
            end else begin
                check_iq(want_name_q[0], want_data_q[0], out_data);
                check_flags(want_name_q[0], want_user_q[0], want_last_q[0], out_user, out_last);
                void'(want_data_q.pop_front());
                void'(want_user_q.pop_front());
                void'(want_last_q.pop_front());
                void'(want_name_q.pop_front());
                checked_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, beats still missing", cycle_count));
        end
    end

    initial begin
        iq_word_u    w;
        logic [31:0] sat_words [4];
        seed_dummy    = $urandom(SEED);
        clk           = 1'b0;
        rst_n         = 1'b0;
        clk_en        = 1'b1;
        ch_bw         = 4'd0;
        in_valid      = 1'b0;
        in_data       = '0;
        in_user       = '0;
        in_last       = 1'b0;
        out_ready     = 1'b1;
        ready_rand    = 1'b0;
        en_rand       = 1'b0;
        checked_count = 0;
        cycle_count   = 0;
        cur_test      = "reset";
        sat_words     = '{32'h7fff7fff, 32'h80008000, 32'h7fff8000, 32'h80007fff};

        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // idle pipeline right after reset
        @(negedge clk);
        check_bit("reset out_valid", 1'b0, out_valid);
        check_bit("reset in_ready", 1'b1, in_ready);
        next_drive_point();

        // every code with random samples
        cur_test = "table sweep";
        for (int c = 0; c < 16; c++) begin
            for (int b = 0; b < 4; b++) begin
                w.raw = $urandom;
                send_beat(w, 4'(c), USR_ID_BW'(b), b == 3);
            end
        end
        drain();

        // full scale at the two largest gains
        cur_test = "saturation";
        for (int c = 1; c <= 2; c++) begin
            for (int k = 0; k < 4; k++) begin
                w.raw = sat_words[k];
                send_beat(w, 4'(c), USR_ID_BW'(k), k == 3);
            end
        end
        drain();

        cur_test   = "back-pressure";
        ready_rand = 1'b1;
        for (int n = 0; n < 60; n++) begin
            if (($urandom % 4) == 0) begin
                idle_cycles(1);
            end
            w.raw = $urandom;
            send_beat(w, 4'd1, USR_ID_BW'($urandom), (n % 8) == 7);
        end
        drain();

        cur_test = "clock enable";
        en_rand  = 1'b1;
        for (int n = 0; n < 60; n++) begin
            w.raw = $urandom;
            send_beat(w, 4'd4, USR_ID_BW'($urandom), (n % 5) == 4);
        end
        drain();

        // new code on every beat and changes while idle too
        cur_test   = "ch_bw change";
        ready_rand = 1'b1;
        en_rand    = 1'b1;
        for (int n = 0; n < 60; n++) begin
            if (($urandom % 6) == 0) begin
                in_valid = 1'b0;
                ch_bw    = 4'($urandom);
                next_drive_point();
            end
            w.raw = $urandom;
            send_beat(w, 4'($urandom), USR_ID_BW'($urandom), (n % 4) == 3);
        end
        drain();

        if (checked_count == NUM_BEATS && want_data_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run($sformatf("checked %0d beats out of %0d", checked_count, NUM_BEATS));
        end
    end

endmodule

// ==== sim.f ====
logic/fft_gain_pkg.sv
logic/fft_gain_ctrl.sv
logic/iq_frac_mult.sv
logic/iq_shift_sat.sv
logic/fft_gain_top.sv
tb/fft_gain_sva.sv
tb/fft_gain_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the gain stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fft_gain_tb \
    -Mdir build \
    -f sim.f

# the run log decides the result
./build/Vfft_gain_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "testbench reported an error"
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
